// File: Bender.yml
package:
  name: axis_shift_buffer

sources:
  - include_dirs:
      - source
    files:
      - source/shift_cfg_pkg.sv
      - source/shift_data_pkg.sv
      - source/config_capture.sv
      - source/row_skid_buffer.sv
      - source/shift_ctrl.sv
      - source/shift_datapath.sv
      - source/block_counters.sv
      - source/axis_shift_buffer.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - sim/shift_buffer_checker.sv
      - sim/tb_shift_buffer.sv

// File: sim/shift_buffer_checker.sv
`timescale 1ns/1ps
`default_nettype none

module shift_buffer_checker (
    input wire logic                      aclk,
    input wire logic                      reset,
    input wire logic                      s_ready,
    input wire logic                      m_valid,
    input wire logic                      m_ready,
    input wire logic                      m_last,
    input wire shift_data_pkg::out_row_t  m_data,
    input wire shift_cfg_pkg::beat_user_t m_user
);

    int fail_count = 0; // summed into the testbench end line

    // a stalled beat has to sit still until it is taken
    property held_under_backpressure;
        @(posedge aclk) disable iff (reset)
            (m_valid && !m_ready) |=>
                (m_valid && $stable(m_data) && $stable(m_last) && $stable(m_user));
    endproperty

    property last_needs_valid;
        @(posedge aclk) disable iff (reset) m_last |-> m_valid;
    endproperty

    // input side open right out of reset
    property ready_after_reset;
        @(posedge aclk) reset |=> s_ready;
    endproperty

    // output side empty, side info cleared
    property empty_after_reset;
        @(posedge aclk) reset |=> (!m_valid && !m_last && (m_user == '0));
    endproperty

    hold_a: assert property (held_under_backpressure) else begin
        fail_count++;
        $error("output beat changed while m_ready was low");
    end

    last_a: assert property (last_needs_valid) else begin
        fail_count++;
        $error("m_last high without m_valid");
    end

    ready_a: assert property (ready_after_reset) else begin
        fail_count++;
        $error("s_ready not high after reset");
    end

    empty_a: assert property (empty_after_reset) else begin
        fail_count++;
        $error("output not empty after reset");
    end

endmodule

bind axis_shift_buffer shift_buffer_checker chk0 (
    .aclk, .reset, .s_ready, .m_valid, .m_ready, .m_last, .m_data, .m_user
);

`default_nettype wire

// File: sim/tb_shift_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "shift_params.svh"

module tb_shift_buffer;

    import shift_cfg_pkg::*;
    import shift_data_pkg::*;

    localparam int TEST_ROWS   = 34; // 20 + 6 + 8 over three runs
    localparam int WATCHDOG_NS = TEST_ROWS * `KERNEL_H_MAX * 8 * 40;

    logic                       aclk;
    logic                       reset;
    logic                       start;
    shift_cfg_t                 cfg;
    in_row_t                    s_data;
    logic                       s_valid;
    logic                       s_ready;
    out_row_t                   m_data;
    logic                       m_valid;
    logic                       m_ready;
    logic                       m_last;
    beat_user_t                 m_user;
    logic [`KERNEL_H_WIDTH-1:0] kernel_h_1_out;
    logic [`KERNEL_W_WIDTH-1:0] kernel_w_1_out;

    integer     seed;
    shift_cfg_t run_cfg;        // what the model believes was captured
    in_row_t    row_q[$];       // accepted rows, oldest first
    int         idx_q[$];       // their index inside the run
    int         row_index;
    int         beat_k;         // next expected beat of the head row
    int         in_count;       // rows accepted
    int         issued_count;   // rows put on s_data
    int         send_limit;
    int         idle_pct;       // chance of an s_valid gap
    int         ready_pct;      // chance of m_ready high
    int         beat_count;
    int         expected_beats;
    int         check_count;
    int         error_count;

    axis_shift_buffer dut0 (
        .aclk, .reset, .start, .cfg, .s_data, .s_valid, .s_ready,
        .m_data, .m_valid, .m_ready, .m_last, .m_user, .kernel_h_1_out, .kernel_w_1_out
    );

    always #20 aclk = ~aclk;

    function automatic int roll_percent();
        return int'(($random(seed) & 32'h7fff_ffff) % 100);
    endfunction

    function automatic in_row_t random_row();
        in_row_t row;
        for (int i = 0; i < `IN_WORDS; i++) begin
            row[i] = word_t'($random(seed));
        end
        return row;
    endfunction

    function automatic shift_cfg_t make_cfg(
        input logic [`KERNEL_H_WIDTH-1:0] kh,
        input logic [`KERNEL_W_WIDTH-1:0] kw,
        input logic                       mx,
        input logic                       rl,
        input logic [`CIN_WIDTH-1:0]      cin,
        input logic [`COLS_WIDTH-1:0]     cols
    );
        shift_cfg_t c;
        c.kernel_h_1 = kh;
        c.kernel_w_1 = kw;
        c.is_max     = mx;
        c.is_relu    = rl;
        c.cin_1      = cin;
        c.cols_1     = cols;
        return c;
    endfunction

    // expected beat built straight from the row: words k..k+CONV_UNITS-1
    task automatic check_beat();
        in_row_t    row;
        out_row_t   exp_data;
        beat_user_t exp_user;
        logic       exp_last;
        int         r;
        int         cin_n;
        int         col;
        int         target;
        beat_count++; // every output transfer, matched or not
        assert (row_q.size() != 0) else begin
            error_count++;
            $display("output beat at %0t with no accepted row left to match it", $time);
        end
        if (row_q.size() == 0) begin
            return;
        end
        row    = row_q[0];
        r      = idx_q[0];
        cin_n  = int'(run_cfg.cin_1) + 1;
        col    = (r / cin_n) % (int'(run_cfg.cols_1) + 1); // column block of this row
        target = int'(run_cfg.cols_1) - int'(run_cfg.kernel_w_1) / 2 - 1;
        for (int i = 0; i < `CONV_UNITS; i++) begin
            exp_data[i] = row[i + beat_k];
        end
        exp_last              = (beat_k == run_cfg.kernel_h_1) && (r % cin_n == cin_n - 1);
        exp_user.is_1x1       = (run_cfg.kernel_h_1 == '0);
        exp_user.is_max       = run_cfg.is_max;
        exp_user.is_relu      = run_cfg.is_relu;
        exp_user.is_cols_1_k2 = (col == target);
        check_count += 3;
        assert (m_data == exp_data) else begin
            error_count++;
            $display("Fail at %0t: row %0d beat %0d data %h, expected %h",
                     $time, r, beat_k, m_data, exp_data);
        end
        assert (m_last == exp_last) else begin
            error_count++;
            $display("Fail at %0t: row %0d beat %0d m_last %b, expected %b",
                     $time, r, beat_k, m_last, exp_last);
        end
        assert (m_user == exp_user) else begin
            error_count++;
            $display("Fail at %0t: row %0d beat %0d m_user %b, expected %b",
                     $time, r, beat_k, m_user, exp_user);
        end
        if (beat_k == run_cfg.kernel_h_1) begin
            void'(row_q.pop_front()); // row fully shifted out
            void'(idx_q.pop_front());
            beat_k = 0;
        end else begin
            beat_k++;
        end
    endtask

    // sample both handshakes on the rising edge
    always @(posedge aclk) begin
        if (!reset) begin
            if (s_valid && s_ready) begin
                row_q.push_back(s_data);
                idx_q.push_back(row_index);
                row_index++;
                in_count++;
                expected_beats += int'(run_cfg.kernel_h_1) + 1;
            end
            if (m_valid && m_ready) begin
                check_beat();
            end
        end
    end

    // one process owns the seed, so the random sequence is fixed
    always @(negedge aclk) begin
        if (!reset) begin
            m_ready = (roll_percent() < ready_pct);
            if (s_valid && in_count == issued_count) begin
                s_valid = 1'b0; // taken on the last rising edge
            end
            if (!s_valid && issued_count < send_limit && roll_percent() >= idle_pct) begin
                s_data  = random_row();
                s_valid = 1'b1;
                issued_count++;
            end
        end
    end

    task automatic apply_config(input shift_cfg_t c);
        @(negedge aclk);
        cfg   = c;
        start = 1'b1;
        @(negedge aclk);
        start     = 1'b0;
        run_cfg   = c;
        row_index = 0; // counters sit at zero between runs
        check_count++;
        assert (kernel_h_1_out == c.kernel_h_1 && kernel_w_1_out == c.kernel_w_1) else begin
            error_count++;
            $display("Fail at %0t: kernel sizes %0d/%0d after start, expected %0d/%0d",
                     $time, kernel_h_1_out, kernel_w_1_out, c.kernel_h_1, c.kernel_w_1);
        end
    endtask

    task automatic cfg_without_start(input shift_cfg_t c);
        @(negedge aclk);
        cfg = c;
        repeat (3) @(negedge aclk);
        check_count++;
        assert (kernel_h_1_out == run_cfg.kernel_h_1 && kernel_w_1_out == run_cfg.kernel_w_1)
        else begin
            error_count++;
            $display("Fail at %0t: kernel sizes %0d/%0d moved without start",
                     $time, kernel_h_1_out, kernel_w_1_out);
        end
    endtask

    // knobs change on the rising edge, away from the driver
    task automatic run_rows(input int n, input int idle, input int ready);
        @(posedge aclk);
        idle_pct   = idle;
        ready_pct  = ready;
        send_limit = send_limit + n;
        @(negedge aclk);
        while (in_count != send_limit || row_q.size() != 0 || m_valid) begin
            @(negedge aclk);
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run still busy after %0d ns, output stream stalled", WATCHDOG_NS);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        seed           = 32'hd73c_e0e3;
        aclk           = 1'b0;
        reset          = 1'b1;
        start          = 1'b0;
        cfg            = '0;
        s_data         = '0;
        s_valid        = 1'b0;
        m_ready        = 1'b0;
        run_cfg        = '0;
        row_index      = 0;
        beat_k         = 0;
        in_count       = 0;
        issued_count   = 0;
        send_limit     = 0;
        idle_pct       = 0;
        ready_pct      = 100;
        beat_count     = 0;
        expected_beats = 0;
        check_count    = 0;
        error_count    = 0;
        repeat (10) @(posedge aclk);
        @(negedge aclk);
        reset = 1'b0;

        // 3x3, four channels, five column blocks, heavy stalls
        apply_config(make_cfg(2'd2, 2'd2, 1'b1, 1'b0, 4'd3, 5'd4));
        run_rows(20, 20, 50);
        cfg_without_start(make_cfg(2'd0, 2'd1, 1'b0, 1'b1, 4'd7, 5'd9));

        // 1x1, every row closes its group
        apply_config(make_cfg(2'd0, 2'd0, 1'b0, 1'b1, 4'd0, 5'd2));
        run_rows(6, 40, 70);

        // full rate, back to back loads
        apply_config(make_cfg(2'd1, 2'd1, 1'b1, 1'b1, 4'd1, 5'd3));
        run_rows(8, 0, 100);

        check_count++;
        assert (beat_count == expected_beats) else begin
            error_count++;
            $display("beat count mismatch, %0d beats seen but %0d expected",
                     beat_count, expected_beats);
        end
        $display("checks %0d, beats %0d, errors %0d, assertion failures %0d",
                 check_count, beat_count, error_count, dut0.chk0.fail_count);
        if (error_count == 0 && dut0.chk0.fail_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/axis_shift_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "shift_params.svh"

module axis_shift_buffer (
    input  wire logic                      aclk,
    input  wire logic                      reset,
    input  wire logic                      start,
    input  wire shift_cfg_pkg::shift_cfg_t cfg,
    input  wire shift_data_pkg::in_row_t   s_data,
    input  wire logic                      s_valid,
    output      logic                      s_ready,
    output      shift_data_pkg::out_row_t  m_data,
    output      logic                      m_valid,
    input  wire logic                      m_ready,
    output      logic                      m_last,
    output      shift_cfg_pkg::beat_user_t m_user,
    output      logic [`KERNEL_H_WIDTH-1:0] kernel_h_1_out,
    output      logic [`KERNEL_W_WIDTH-1:0] kernel_w_1_out
);

    import shift_cfg_pkg::*;
    import shift_data_pkg::*;

    shift_cfg_t cfg_q;
    logic       is_1x1;
    in_row_t    row_data;
    logic       row_valid;
    logic       row_take;
    logic       load;
    logic       shift;
    logic       row_done;
    logic       cin_last;
    logic       cols_1_k2;

    config_capture u_cfg (.aclk, .reset, .start, .cfg, .cfg_q, .is_1x1);

    row_skid_buffer u_skid (
        .aclk, .reset, .s_data, .s_valid, .row_take, .s_ready, .row_data, .row_valid
    );

    shift_ctrl u_ctrl (
        .aclk, .reset, .cfg_q, .row_valid, .m_ready, .cin_last,
        .row_take, .load, .shift, .row_done, .m_valid, .m_last
    );

    shift_datapath u_data (.aclk, .reset, .row_data, .load, .shift, .m_data);

    block_counters u_cnt (.aclk, .reset, .cfg_q, .row_done, .m_last, .cin_last, .cols_1_k2);

    // flags tied to start, except the column flag which follows the block
    assign m_user = '{
        is_1x1:       is_1x1,
        is_max:       cfg_q.is_max,
        is_relu:      cfg_q.is_relu,
        is_cols_1_k2: cols_1_k2
    };

    assign kernel_h_1_out = cfg_q.kernel_h_1;
    assign kernel_w_1_out = cfg_q.kernel_w_1;

endmodule

`default_nettype wire

// File: source/block_counters.sv
`timescale 1ns/1ps
`default_nettype none

`include "shift_params.svh"

module block_counters (
    input  wire logic                      aclk,
    input  wire logic                      reset,
    input  wire shift_cfg_pkg::shift_cfg_t cfg_q,
    input  wire logic                      row_done,  // last shift of a row transferred
    input  wire logic                      m_last,    // ...and it closed a channel group
    output      logic                      cin_last,
    output      logic                      cols_1_k2
);

    logic [`CIN_WIDTH-1:0]  cin_count;
    logic [`CIN_WIDTH-1:0]  cin_next;
    logic [`COLS_WIDTH-1:0] cols_count;
    logic [`COLS_WIDTH-1:0] cols_next;
    logic [`COLS_WIDTH-1:0] kw_half;     // kernel_w_1 / 2, widened
    logic [`COLS_WIDTH-1:0] cols_target; // block before the right border
    logic                   cols_step;

    assign cin_next = (cin_count == cfg_q.cin_1) ? '0 : cin_count + 1'b1;

    // row being loaded in the same cycle already belongs to the next count
    // so look through the update to keep back to back 1x1 rows right
    assign cin_last = ((row_done ? cin_next : cin_count) == cfg_q.cin_1);

    always_ff @(posedge aclk) begin
        if (reset) begin
            cin_count <= '0;
        end else if (row_done) begin
            cin_count <= cin_next;
        end
    end

    // column block ends with the last beat of a channel group
    assign cols_step   = row_done && m_last;
    assign cols_next   = (cols_count == cfg_q.cols_1) ? '0 : cols_count + 1'b1;
    assign kw_half     = {{(`COLS_WIDTH - `KERNEL_W_WIDTH + 1){1'b0}}, cfg_q.kernel_w_1[1]};
    assign cols_target = cfg_q.cols_1 - kw_half - 1'b1;

    always_ff @(posedge aclk) begin
        if (reset) begin
            cols_count <= '0;
            cols_1_k2  <= 1'b0;
        end else if (cols_step) begin
            cols_count <= cols_next;
            cols_1_k2  <= (cols_next == cols_target); // held for the whole block
        end
    end

endmodule

`default_nettype wire

// File: source/config_capture.sv
`timescale 1ns/1ps
`default_nettype none

module config_capture (
    input  wire logic                     aclk,
    input  wire logic                     reset,
    input  wire logic                     start,
    input  wire shift_cfg_pkg::shift_cfg_t cfg,
    output      shift_cfg_pkg::shift_cfg_t cfg_q,
    output      logic                     is_1x1
);

    // config is only looked at on start
    // everything downstream assumes it stays put for the run
    always_ff @(posedge aclk) begin
        if (reset) begin
            cfg_q <= '0; // kernel_h_1 = 0, flags off, counts zero
        end else if (start) begin
            cfg_q <= cfg;
        end
    end

    // 1x1 decoded once here instead of comparing everywhere
    // stays low after reset so m_user starts all zero
    always_ff @(posedge aclk) begin
        if (reset) begin
            is_1x1 <= 1'b0;
        end else if (start) begin
            is_1x1 <= (cfg.kernel_h_1 == '0); // one beat per row
        end
    end

endmodule

`default_nettype wire

// File: source/row_skid_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module row_skid_buffer (
    input  wire logic                    aclk,
    input  wire logic                    reset,
    input  wire shift_data_pkg::in_row_t s_data,
    input  wire logic                    s_valid,
    input  wire logic                    row_take,  // pop from shift_ctrl
    output      logic                    s_ready,
    output      shift_data_pkg::in_row_t row_data,
    output      logic                    row_valid
);

    import shift_data_pkg::*;

    in_row_t    head_q;     // oldest row, seen by the datapath
    in_row_t    tail_q;     // second row, only filled while head is waiting
    logic [1:0] count_q;    // 0, 1 or 2 rows held
    logic [1:0] count_next;
    logic       push;

    assign push      = s_valid && s_ready;
    assign row_valid = (count_q != 2'd0);
    assign row_data  = head_q;

    always_comb begin
        count_next = count_q;
        if (push && !row_take) begin
            count_next = count_q + 2'd1;
        end else if (row_take && !push) begin
            count_next = count_q - 2'd1;
        end
    end

    // payload, no reset
    always_ff @(posedge aclk) begin
        case (count_q)
            2'd0: if (push) head_q <= s_data;
            2'd1: begin
                if (push && row_take) begin
                    head_q <= s_data;   // pass straight through
                end else if (push) begin
                    tail_q <= s_data;   // head still busy
                end
            end
            default: if (row_take) head_q <= tail_q; // never pushed here, ready is low
        endcase
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            count_q <= 2'd0;
            s_ready <= 1'b1;
        end else begin
            count_q <= count_next;
            s_ready <= (count_next != 2'd2); // registered, drops only when full
        end
    end

endmodule

`default_nettype wire

// File: source/shift_cfg_pkg.sv
`default_nettype none

`include "shift_params.svh"

package shift_cfg_pkg;

    // run configuration, sampled on start
    // all size fields hold the real size minus one
    typedef struct packed {
        logic [`KERNEL_H_WIDTH-1:0] kernel_h_1; // number of shifts per row minus one
        logic [`KERNEL_W_WIDTH-1:0] kernel_w_1; // only used for the column flag
        logic                       is_max;     // max pool downstream
        logic                       is_relu;    // relu downstream
        logic [`CIN_WIDTH-1:0]      cin_1;      // rows per channel group minus one
        logic [`COLS_WIDTH-1:0]     cols_1;     // column blocks minus one
    } shift_cfg_t;

    // side info sent with each output beat
    typedef struct packed {
        logic is_1x1;       // kernel height one
        logic is_max;
        logic is_relu;
        logic is_cols_1_k2; // column block before the right border
    } beat_user_t;

endpackage

`default_nettype wire

// File: source/shift_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "shift_params.svh"

module shift_ctrl (
    input  wire logic                      aclk,
    input  wire logic                      reset,
    input  wire shift_cfg_pkg::shift_cfg_t cfg_q,
    input  wire logic                      row_valid,
    input  wire logic                      m_ready,
    input  wire logic                      cin_last,   // for the row entering the output regs
    output      logic                      row_take,
    output      logic                      load,
    output      logic                      shift,
    output      logic                      row_done,
    output      logic                      m_valid,
    output      logic                      m_last
);

    logic [`KERNEL_H_WIDTH-1:0] shift_idx;     // shift of the beat now on m_data
    logic [`KERNEL_H_WIDTH-1:0] shift_idx_inc;
    logic                       xfer;          // output handshake
    logic                       last_beat;     // beat on m_data is the last shift of its row

    assign xfer          = m_valid && m_ready;
    assign last_beat     = (shift_idx == cfg_q.kernel_h_1);
    assign shift_idx_inc = shift_idx + 1'b1;

    // all transfer decisions live here
    // load when output regs are empty, or their last shift is leaving now
    assign load     = row_valid && (!m_valid || (xfer && last_beat));
    assign shift    = xfer && !last_beat;
    assign row_done = xfer && last_beat;
    assign row_take = load;  // row leaves the skid buffer as it is copied

    // m_valid, shift index and last flag all move with the data regs
    always_ff @(posedge aclk) begin
        if (reset) begin
            m_valid   <= 1'b0;
            shift_idx <= '0;
            m_last    <= 1'b0;
        end else if (load) begin
            m_valid   <= 1'b1;
            shift_idx <= '0;
            // 1x1: first beat is also the last one
            m_last    <= (cfg_q.kernel_h_1 == '0) && cin_last;
        end else if (shift) begin
            shift_idx <= shift_idx_inc;
            m_last    <= (shift_idx_inc == cfg_q.kernel_h_1) && cin_last;
        end else if (row_done) begin
            m_valid   <= 1'b0; // nothing waiting, go empty
            m_last    <= 1'b0;
        end
        // otherwise hold, covers m_ready low
    end

endmodule

`default_nettype wire

// File: source/shift_data_pkg.sv
`default_nettype none

`include "shift_params.svh"

package shift_data_pkg;

    // one pixel
    typedef logic [`WORD_WIDTH-1:0] word_t;

    // padded input row, word 0 in the low bits
    typedef word_t [`IN_WORDS-1:0] in_row_t;

    // one shifted output beat
    typedef word_t [`CONV_UNITS-1:0] out_row_t;

    // word k of an out_row_t beat with shift s is word k+s of the row

endpackage

`default_nettype wire

// File: source/shift_datapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "shift_params.svh"

module shift_datapath (
    input  wire logic                    aclk,
    input  wire logic                    reset,
    input  wire shift_data_pkg::in_row_t row_data,
    input  wire logic                    load,   // copy whole row
    input  wire logic                    shift,  // move down one word
    output      shift_data_pkg::out_row_t m_data
);

    import shift_data_pkg::*;

    in_row_t data_q;    // IN_WORDS word registers
    in_row_t data_next;

    // load and shift never fire together
    always_comb begin
        data_next = data_q;
        if (load) begin
            data_next = row_data;
        end else if (shift) begin
            for (int i = 0; i < `IN_WORDS - 1; i++) begin
                data_next[i] = data_q[i+1]; // word i takes its upper neighbour
            end
            // top word keeps its old value, it never reaches m_data again
        end
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            data_q <= '0;
        end else begin
            data_q <= data_next;
        end
    end

    // low CONV_UNITS words go out
    assign m_data = data_q[`CONV_UNITS-1:0];

endmodule

`default_nettype wire

// File: source/shift_params.svh
`ifndef SHIFT_PARAMS_SVH
`define SHIFT_PARAMS_SVH

// pixel word
`define WORD_WIDTH      8

// words in one output beat, one per conv unit
`define CONV_UNITS      8

// largest kernel the buffer can shift for
`define KERNEL_H_MAX    3
`define KERNEL_W_MAX    3

// padded input row: conv units plus kernel overlap
`define IN_WORDS        (`CONV_UNITS + `KERNEL_H_MAX - 1)

// kernel size minus one, 0..KERNEL_*_MAX-1
`define KERNEL_H_WIDTH  2
`define KERNEL_W_WIDTH  2

// channel and column block counters
`define CIN_WIDTH       4
`define COLS_WIDTH      5

`endif

// File: vlog.f
+incdir+source
source/shift_cfg_pkg.sv
source/shift_data_pkg.sv
source/config_capture.sv
source/row_skid_buffer.sv
source/shift_ctrl.sv
source/shift_datapath.sv
source/block_counters.sv
source/axis_shift_buffer.sv
sim/shift_buffer_checker.sv
sim/tb_shift_buffer.sv
